// File: sim.f
hw/gpio_pkg.sv
hw/gpio_bus_port.sv
hw/gpio_regs.sv
hw/gpio_edge_detect.sv
hw/gpio_top.sv
test/gpio_sva.sv
test/gpio_tb.sv

// File: test/gpio_tb.sv
/*
 * GPIO peripheral testbench.
 * Drives bus reads and writes and input pin steps, keeps a model of
 * the registers and compares every response and the pin outputs
 * against it, including stalled responses.
 */

`timescale 1ns/1ps

module gpio_tb;

    localparam int addr_width = 16;
    localparam int data_width = 16;
    localparam int gpio_width = 16;
    localparam logic [15:0] base_addr = 16'hFF00;
    localparam int timeout_cycles = 6000;           // About 300 transactions of 12 cycles, plus margin.

    logic clk;
    logic reset;
    logic req_valid;
    logic req_ready;
    logic req_write;
    logic [15:0] req_addr;
    logic [15:0] req_wdata;
    logic rsp_valid;
    logic rsp_ready;
    logic [15:0] rsp_rdata;
    logic rsp_error;
    logic [15:0] gpi;
    logic [15:0] gpo;
    logic irq;

    integer seed;
    integer cycle_count;
    logic [15:0] gpo_model;
    logic [15:0] rise_model;
    logic [15:0] fall_model;
    logic [15:0] pend_model;
    logic [15:0] gpi_model;

    gpio_top #(
        .addr_width (addr_width),
        .data_width (data_width),
        .gpio_width (gpio_width),
        .base_addr  (base_addr)
    ) u_dut (
        .clk (clk), .reset (reset),
        .req_valid (req_valid), .req_ready (req_ready), .req_write (req_write),
        .req_addr (req_addr), .req_wdata (req_wdata),
        .rsp_valid (rsp_valid), .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata), .rsp_error (rsp_error),
        .gpi (gpi), .gpo (gpo), .irq (irq)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
            $display("TESTS FAILED");
            $fatal(1, "Simulation stopped by the cycle limit.");
        end
    end

    // Sticky flags are cleared by a write of one, and a new edge wins over a clear.
    function automatic logic [15:0] expect_pending(input logic [15:0] old_pend,
            input logic [15:0] old_sync, input logic [15:0] new_sync,
            input logic [15:0] rise_en, input logic [15:0] fall_en, input logic [15:0] clr);
        logic [15:0] rise;
        logic [15:0] fall;
        rise = new_sync & ~old_sync;
        fall = ~new_sync & old_sync;
        return (old_pend & ~clr) | (rise & rise_en) | (fall & fall_en);
    endfunction

    function automatic logic [15:0] addr_of(input gpio_pkg::reg_offset_t r);
        return base_addr + 16'(r);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
            input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: actual %h expected %h", name, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "Check failed.");
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic start_request(input logic write, input logic [15:0] addr,
            input logic [15:0] wdata);
        logic ready_seen;
        ready_seen = 1'b0;
        req_valid = 1'b1;
        req_write = write;
        req_addr = addr;
        req_wdata = wdata;
        while (!ready_seen) begin
            ready_seen = req_ready;                 // Stable until the next edge.
            wait_cycles(1);
        end
        req_valid = 1'b0;
    endtask

    task automatic finish_response(output logic [15:0] rdata, output logic err);
        while (!rsp_valid) begin
            wait_cycles(1);
        end
        rdata = rsp_rdata;
        err = rsp_error;
        wait_cycles(1);
    endtask

    task automatic do_write(input logic [15:0] addr, input logic [15:0] data, output logic err);
        logic [15:0] unused;
        start_request(1'b1, addr, data);
        finish_response(unused, err);
    endtask

    task automatic do_read(input logic [15:0] addr, output logic [15:0] data, output logic err);
        start_request(1'b0, addr, 16'h0000);
        finish_response(data, err);
    endtask

    task automatic write_reg(input gpio_pkg::reg_offset_t r, input logic [15:0] data);
        logic err;
        do_write(addr_of(r), data, err);
        check_value("rsp_error", err, 0);
        case (r)
            gpio_pkg::reg_gpo: gpo_model = data;
            gpio_pkg::reg_rise_en: rise_model = data;
            gpio_pkg::reg_fall_en: fall_model = data;
            gpio_pkg::reg_pending: pend_model = expect_pending(pend_model, gpi_model,
                gpi_model, rise_model, fall_model, data);
            default: ;
        endcase
    endtask

    task automatic read_check(input gpio_pkg::reg_offset_t r, input logic [15:0] expected);
        logic [15:0] data;
        logic err;
        do_read(addr_of(r), data, err);
        check_value($sformatf("rsp_error(%s)", r.name()), err, 0);
        check_value($sformatf("rsp_rdata(%s)", r.name()), data, expected);
    endtask

    task automatic step_gpi(input logic [15:0] value, input int settle);
        gpi = value;
        wait_cycles(settle);
        pend_model = expect_pending(pend_model, gpi_model, value, rise_model, fall_model, 0);
        gpi_model = value;
    endtask

    task automatic expect_error(input logic write, input logic [15:0] addr);
        logic [15:0] data;
        logic err;
        if (write) begin
            do_write(addr, $random(seed), err);
        end else begin
            do_read(addr, data, err);
            check_value("rsp_rdata", data, 0);
        end
        check_value("rsp_error", err, 1);
    endtask

    initial begin
        logic [15:0] data;
        logic [15:0] addr;
        logic [15:0] first_data;
        logic first_err;
        int hold;
        int i;
        int n;
        seed = 3;
        cycle_count = 0;
        clk = 1'b0;
        reset = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        rsp_ready = 1'b1;
        gpi = '0;                                   // Low during reset, so no start-up edge.
        {gpo_model, rise_model, fall_model, pend_model, gpi_model} = '0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b1;

        for (i = 0; i < 5; i++) begin
            read_check(gpio_pkg::reg_offset_t'(i), 16'h0000);
        end
        check_value("gpo", gpo, 0);
        check_value("irq", irq, 0);

        repeat (20) begin
            write_reg(gpio_pkg::reg_gpo, $random(seed));
            read_check(gpio_pkg::reg_gpo, gpo_model);
            check_value("gpo", gpo, gpo_model);
        end
        repeat (10) begin
            step_gpi($random(seed), 3);
            read_check(gpio_pkg::reg_gpi, gpi_model);
        end

        for (i = 0; i < 10; i++) begin
            addr = $random(seed);
            if (addr >= base_addr) addr = addr - 16'h0100;
            expect_error(i[0], addr);
            addr = base_addr + 16'(gpio_pkg::window_words) + ($random(seed) & 16'h00F7);
            expect_error(i[0], addr);
        end
        for (i = 5; i < 8; i++) begin
            expect_error(1'b1, base_addr + 16'(i));
            expect_error(1'b0, base_addr + 16'(i));
        end
        read_check(gpio_pkg::reg_gpo, gpo_model);

        repeat (4) begin
            write_reg(gpio_pkg::reg_rise_en, $random(seed));
            write_reg(gpio_pkg::reg_fall_en, $random(seed));
            read_check(gpio_pkg::reg_rise_en, rise_model);
            read_check(gpio_pkg::reg_fall_en, fall_model);
            repeat (10) begin
                step_gpi($random(seed), 6);
                check_value("irq", irq, |pend_model);
                read_check(gpio_pkg::reg_pending, pend_model);
            end
        end

        n = 0;
        while (pend_model != 0 && n < 20) begin
            write_reg(gpio_pkg::reg_pending, $random(seed) & $random(seed));
            read_check(gpio_pkg::reg_pending, pend_model);
            check_value("irq", irq, |pend_model);
            n++;
        end
        write_reg(gpio_pkg::reg_pending, 16'hFFFF);
        read_check(gpio_pkg::reg_pending, 16'h0000);
        check_value("irq", irq, 0);

        repeat (10) begin
            hold = {$random(seed)} % 6;
            write_reg(gpio_pkg::reg_gpo, $random(seed));
            write_reg(gpio_pkg::reg_rise_en, $random(seed));
            start_request(1'b0, addr_of(gpio_pkg::reg_gpo), 16'h0000);
            rsp_ready = 1'b0;
            while (!rsp_valid) begin
                wait_cycles(1);
            end
            first_data = rsp_rdata;
            first_err = rsp_error;
            check_value("rsp_rdata", first_data, gpo_model);
            check_value("rsp_error", first_err, 0);
            req_valid = 1'b1;                       // Second request waits behind the stall.
            req_write = 1'b0;
            req_addr = addr_of(gpio_pkg::reg_rise_en);
            req_wdata = 16'h0000;
            check_value("req_ready", req_ready, 0);
            repeat (hold) begin
                wait_cycles(1);
                check_value("rsp_valid", rsp_valid, 1);
                check_value("rsp_rdata", rsp_rdata, first_data);
                check_value("rsp_error", rsp_error, first_err);
                check_value("req_ready", req_ready, 0);
            end
            rsp_ready = 1'b1;
            start_request(1'b0, addr_of(gpio_pkg::reg_rise_en), 16'h0000);
            finish_response(data, first_err);
            check_value("rsp_error", first_err, 0);
            check_value("rsp_rdata", data, rise_model);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: test/gpio_sva.sv
/*
 * GPIO peripheral bus checks.
 * Concurrent assertions on the request and response handshakes,
 * the access latency and the state right after reset.
 */

`timescale 1ns/1ps

module gpio_sva #(
    parameter int data_width = 16
) (
    input logic                    clk,
    input logic                    reset,
    input logic                    req_valid,
    input logic                    req_ready,
    input logic                    rsp_valid,
    input logic                    rsp_ready,
    input logic [data_width-1:0]   rsp_rdata,
    input logic                    rsp_error,
    input logic                    irq
);

    rsp_hold_stable: assert property (@(posedge clk) disable iff (!reset)
        rsp_valid && !rsp_ready |=> $stable(rsp_rdata) && $stable(rsp_error))
        else $error("Response data or error changed while stalled.");

    no_accept_during_rsp: assert property (@(posedge clk) disable iff (!reset)
        rsp_valid |-> !req_ready)
        else $error("req_ready high while a response is pending.");

    // Accept, one access cycle, then the response.
    rsp_latency: assert property (@(posedge clk) disable iff (!reset)
        req_valid && req_ready |=> !rsp_valid ##1 rsp_valid)
        else $error("rsp_valid did not follow the accepted request by two cycles.");

    reset_quiet: assert property (@(posedge clk)
        !reset |=> !irq && !rsp_valid)
        else $error("irq or rsp_valid high right after reset.");

endmodule

bind gpio_top gpio_sva #(.data_width(data_width)) u_sva (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_rdata (rsp_rdata),
    .rsp_error (rsp_error),
    .irq       (irq)
);

// File: hw/gpio_top.sv
/*
 * GPIO peripheral top level.
 * 16 outputs and 16 inputs behind a decoded bus window, with a level
 * interrupt from masked input edges. Connects the bus port, the
 * register block and the input edge detector.
 */

`timescale 1ns/1ps

module gpio_top #(
    parameter int addr_width = 16,
    parameter int data_width = 16,
    parameter int gpio_width = 16,
    parameter logic [addr_width-1:0] base_addr = 16'hFF00
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  logic                    req_write,
    input  logic [addr_width-1:0]   req_addr,
    input  logic [data_width-1:0]   req_wdata,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output logic [data_width-1:0]   rsp_rdata,
    output logic                    rsp_error,
    input  logic [gpio_width-1:0]   gpi,
    output logic [gpio_width-1:0]   gpo,
    output logic                    irq
);

    logic acc_strobe;
    logic acc_write;
    logic [gpio_pkg::offset_bits-1:0] acc_offset;
    logic [data_width-1:0] acc_wdata;
    logic [data_width-1:0] acc_rdata;
    logic acc_bad;
    logic [gpio_width-1:0] gpi_sync;
    logic [gpio_width-1:0] rise_evt;
    logic [gpio_width-1:0] fall_evt;

    gpio_bus_port #(
        .addr_width (addr_width),
        .data_width (data_width),
        .base_addr  (base_addr)
    ) u_bus_port (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_rdata  (rsp_rdata),
        .rsp_error  (rsp_error),
        .acc_strobe (acc_strobe),
        .acc_write  (acc_write),
        .acc_offset (acc_offset),
        .acc_wdata  (acc_wdata),
        .acc_rdata  (acc_rdata),
        .acc_bad    (acc_bad)
    );

    gpio_regs #(
        .data_width (data_width),
        .gpio_width (gpio_width)
    ) u_regs (
        .clk        (clk),
        .reset      (reset),
        .acc_strobe (acc_strobe),
        .acc_write  (acc_write),
        .acc_offset (acc_offset),
        .acc_wdata  (acc_wdata),
        .acc_rdata  (acc_rdata),
        .acc_bad    (acc_bad),
        .gpi_sync   (gpi_sync),
        .rise_evt   (rise_evt),
        .fall_evt   (fall_evt),
        .gpo        (gpo),
        .irq        (irq)
    );

    gpio_edge_detect #(
        .gpio_width (gpio_width)
    ) u_edge_detect (
        .clk        (clk),
        .reset      (reset),
        .gpi        (gpi),
        .gpi_sync   (gpi_sync),
        .rise_evt   (rise_evt),
        .fall_evt   (fall_evt)
    );

endmodule

// File: hw/gpio_edge_detect.sv
/*
 * GPIO input stage.
 * Brings the asynchronous pins into the clock domain through two flops
 * and compares against the previous sample to flag rising and falling
 * edges per pin, each for one cycle.
 */

`timescale 1ns/1ps

module gpio_edge_detect #(
    parameter int gpio_width = 16
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [gpio_width-1:0]   gpi,
    output logic [gpio_width-1:0]   gpi_sync,
    output logic [gpio_width-1:0]   rise_evt,
    output logic [gpio_width-1:0]   fall_evt
);

    logic [gpio_width-1:0] meta_q;
    logic [gpio_width-1:0] sync_q;
    logic [gpio_width-1:0] prev_q;

    always_ff @(posedge clk) begin
        if (!reset) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= gpi;                                  // First stage may go metastable.
            sync_q <= meta_q;
        end
    end

    // A pin held high through reset shows up as one rising edge afterwards.
    always_ff @(posedge clk) begin
        if (!reset) begin
            prev_q <= '0;
        end else begin
            prev_q <= sync_q;
        end
    end

    assign gpi_sync = sync_q;
    assign rise_evt = sync_q & ~prev_q;
    assign fall_evt = ~sync_q & prev_q;

endmodule

// File: hw/gpio_regs.sv
/*
 * GPIO register block.
 * Holds the output latch, the rising and falling edge masks and the
 * sticky pending flags, decodes the word offset for writes and read
 * data, and drives the registered level interrupt.
 */

`timescale 1ns/1ps

module gpio_regs #(
    parameter int data_width = 16,
    parameter int gpio_width = 16
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               acc_strobe,
    input  logic                               acc_write,
    input  logic [gpio_pkg::offset_bits-1:0]   acc_offset,
    input  logic [data_width-1:0]              acc_wdata,
    output logic [data_width-1:0]              acc_rdata,
    output logic                               acc_bad,
    input  logic [gpio_width-1:0]              gpi_sync,
    input  logic [gpio_width-1:0]              rise_evt,
    input  logic [gpio_width-1:0]              fall_evt,
    output logic [gpio_width-1:0]              gpo,
    output logic                               irq
);

    gpio_pkg::reg_offset_t offset;
    logic wr_en;
    logic [gpio_width-1:0] wr_data;
    logic [gpio_width-1:0] gpo_q;
    logic [gpio_width-1:0] rise_en_q;
    logic [gpio_width-1:0] fall_en_q;
    logic [gpio_width-1:0] pending_q;
    logic [gpio_width-1:0] pending_d;
    logic [gpio_width-1:0] set_mask;
    logic [gpio_width-1:0] clr_mask;
    logic irq_q;

    assign offset = gpio_pkg::reg_offset_t'(acc_offset);
    assign wr_en = acc_strobe && acc_write;
    assign wr_data = acc_wdata[gpio_width-1:0];

    assign set_mask = (rise_evt & rise_en_q) | (fall_evt & fall_en_q);
    assign clr_mask = (wr_en && offset == gpio_pkg::reg_pending) ? wr_data : '0;

    // A new event beats a clear of the same bit in the same cycle.
    assign pending_d = (pending_q & ~clr_mask) | set_mask;

    assign gpo = gpo_q;
    assign irq = irq_q;

    // Read data and the reserved offset check.
    always_comb begin
        acc_rdata = '0;
        acc_bad = 1'b0;
        case (offset)
            gpio_pkg::reg_gpo: begin
                acc_rdata = data_width'(gpo_q);
            end
            gpio_pkg::reg_gpi: begin
                acc_rdata = data_width'(gpi_sync);
            end
            gpio_pkg::reg_rise_en: begin
                acc_rdata = data_width'(rise_en_q);
            end
            gpio_pkg::reg_fall_en: begin
                acc_rdata = data_width'(fall_en_q);
            end
            gpio_pkg::reg_pending: begin
                acc_rdata = data_width'(pending_q);
            end
            default: begin
                acc_bad = 1'b1;                             // Offsets 5 to 7.
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            gpo_q <= '0;
            rise_en_q <= '0;
            fall_en_q <= '0;
        end else if (wr_en) begin
            case (offset)
                gpio_pkg::reg_gpo: begin
                    gpo_q <= wr_data;
                end
                gpio_pkg::reg_rise_en: begin
                    rise_en_q <= wr_data;
                end
                gpio_pkg::reg_fall_en: begin
                    fall_en_q <= wr_data;
                end
                default: begin
                end                                         // Pending is handled below; gpi is read only.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            pending_q <= '0;
            irq_q <= 1'b0;
        end else begin
            pending_q <= pending_d;
            irq_q <= |pending_q;                            // One cycle behind the flags.
        end
    end

endmodule

// File: hw/gpio_bus_port.sv
/*
 * GPIO bus slave port.
 * Accepts one request at a time on the valid/ready request channel,
 * checks the address window, issues a single register access strobe
 * and holds the response until the master takes it.
 */

`timescale 1ns/1ps

module gpio_bus_port #(
    parameter int addr_width = 16,
    parameter int data_width = 16,
    parameter logic [addr_width-1:0] base_addr = 16'hFF00
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               req_valid,
    output logic                               req_ready,
    input  logic                               req_write,
    input  logic [addr_width-1:0]              req_addr,
    input  logic [data_width-1:0]              req_wdata,
    output logic                               rsp_valid,
    input  logic                               rsp_ready,
    output logic [data_width-1:0]              rsp_rdata,
    output logic                               rsp_error,
    output logic                               acc_strobe,
    output logic                               acc_write,
    output logic [gpio_pkg::offset_bits-1:0]   acc_offset,
    output logic [data_width-1:0]              acc_wdata,
    input  logic [data_width-1:0]              acc_rdata,
    input  logic                               acc_bad
);

    gpio_pkg::bus_state_t state_q;
    gpio_pkg::bus_state_t state_d;
    logic [addr_width-1:0] addr_delta;
    logic in_window;
    logic accept;
    logic hit_q;
    logic write_q;
    logic [gpio_pkg::offset_bits-1:0] offset_q;
    logic [data_width-1:0] wdata_q;

    // Subtracting first keeps the upper bound free of overflow near the top of the map.
    assign addr_delta = req_addr - base_addr;
    assign in_window = (req_addr >= base_addr) &&
                       (addr_delta < addr_width'(gpio_pkg::window_words));

    assign req_ready = (state_q == gpio_pkg::st_idle);
    assign rsp_valid = (state_q == gpio_pkg::st_resp);
    assign accept = req_valid && req_ready;

    assign acc_strobe = (state_q == gpio_pkg::st_access) && hit_q;  // No access outside the window.
    assign acc_write = write_q;
    assign acc_offset = offset_q;
    assign acc_wdata = wdata_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            gpio_pkg::st_idle: begin
                if (accept) begin
                    state_d = gpio_pkg::st_access;
                end
            end
            gpio_pkg::st_access: begin
                state_d = gpio_pkg::st_resp;                // Access takes exactly one cycle.
            end
            gpio_pkg::st_resp: begin
                if (rsp_ready) begin
                    state_d = gpio_pkg::st_idle;
                end
            end
            default: begin
                state_d = gpio_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state_q <= gpio_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // Request is captured on the accepting edge and stays put until the next accept.
    always_ff @(posedge clk) begin
        if (accept) begin
            hit_q <= in_window;
            write_q <= req_write;
            offset_q <= addr_delta[gpio_pkg::offset_bits-1:0];
            wdata_q <= req_wdata;
        end
    end

    // Response is latched at the end of the access cycle.
    always_ff @(posedge clk) begin
        if (state_q == gpio_pkg::st_access) begin
            rsp_error <= !hit_q || acc_bad;
            rsp_rdata <= (hit_q && !acc_bad) ? acc_rdata : '0;
        end
    end

endmodule

// File: hw/gpio_pkg.sv
/*
 * GPIO peripheral shared definitions.
 * Holds the register offset map, the bus port states and
 * the size of the decoded address window.
 */

package gpio_pkg;

    // Word offsets inside the address window.
    localparam int offset_bits = 3;                  // Offset width inside the window.
    localparam int window_words = 8;                 // Words decoded from base_addr up.

    // Register map. Offsets 5 to 7 are reserved and answer with an error.
    typedef enum logic [offset_bits-1:0] {
        reg_gpo     = 3'd0,                          // Output latch.
        reg_gpi     = 3'd1,                          // Synchronized input pins, read only.
        reg_rise_en = 3'd2,                          // Rising edge interrupt mask.
        reg_fall_en = 3'd3,                          // Falling edge interrupt mask.
        reg_pending = 3'd4                           // Sticky pending flags, write one to clear.
    } reg_offset_t;

    // Bus slave port sequencing.
    typedef enum logic [1:0] {
        st_idle   = 2'd0,                            // Ready for a new request.
        st_access = 2'd1,                            // One register access in progress.
        st_resp   = 2'd2                             // Response held until taken.
    } bus_state_t;

endpackage
